// ==== source/frame_pkg.sv ====
package frame_pkg;

  // ---------------------------------------------------------------------
  // frame geometry
  // ---------------------------------------------------------------------

  // serial data pins per front-end chip
  localparam int mxio = 8;

  // bits per pin per frame, half on d0 and half on d1
  localparam int word_size = 8;

  // deserialized word per channel
  localparam int mxsbits = mxio * word_size;

  // two bits per fastclock cycle on each pin
  localparam int frame_cycles = word_size / 2;
  localparam int phase_bits = $clog2(frame_cycles);

  // ---------------------------------------------------------------------
  // delay line and lock search
  // ---------------------------------------------------------------------

  // depth of the per-bit delay line, also the number of taps
  localparam int srl_depth = 16;
  localparam int tap_bits = $clog2(srl_depth);

  // sof runs two cycles behind data, matching the two word pipeline stages
  localparam int sof_extra_delay = 2;

  // frames between tap checks, gives a new tap time to settle
  localparam int check_period = 4;
  localparam int check_bits = $clog2(check_period);

  // run of aligned frames needed before lock
  localparam int mxstable = 16;
  localparam int stable_bits = $clog2(mxstable);

  localparam int num_channels = 2;

endpackage

// ==== source/bit_delay_line.sv ====
`timescale 1ns/100ps

module bit_delay_line #(
  parameter int width = 1
) (
  input  logic                          fastclock,
  input  logic [width-1:0]              din,
  input  logic [frame_pkg::tap_bits-1:0] tap,
  output logic [width-1:0]              dout
);

  import frame_pkg::*;

  // ---------------------------------------------------------------------
  // one shift row per bit
  // ---------------------------------------------------------------------

  // only srl_depth-1 stored stages, tap 0 reads din straight through
  logic [srl_depth-2:0] shift_row [width];

  // all taps of each row, din at index 0
  logic [srl_depth-1:0] tap_row [width];

  always_comb begin
    for (int b = 0; b < width; b++) begin
      tap_row[b] = {shift_row[b], din[b]};
    end
  end

  // no reset, the line flushes itself within srl_depth cycles
  always_ff @(posedge fastclock) begin
    for (int b = 0; b < width; b++) begin
      shift_row[b] <= tap_row[b][srl_depth-2:0];
    end
  end

  // ---------------------------------------------------------------------
  // registered tap output
  // ---------------------------------------------------------------------

  // total delay din to dout is tap+1 cycles
  // this flop also serves as the fanout stage
  always_ff @(posedge fastclock) begin
    for (int b = 0; b < width; b++) begin
      dout[b] <= tap_row[b][tap];
    end
  end

endmodule

// ==== source/frame_timer.sv ====
`timescale 1ns/100ps

module frame_timer (
  input  logic fastclock,
  input  logic rst,
  output logic frame_tick,
  output logic check_strobe
);

  import frame_pkg::*;

  // position of the current cycle within the frame
  logic [phase_bits-1:0] phase;

  // frames since the last tap check
  logic [check_bits-1:0] frame_cnt;

  logic last_phase;

  assign last_phase = (phase == phase_bits'(frame_cycles - 1));

  always_ff @(posedge fastclock) begin
    if (rst) begin
      phase        <= '0;
      frame_cnt    <= '0;
      frame_tick   <= 1'b0;
      check_strobe <= 1'b0;
    end else begin
      phase <= last_phase ? '0 : phase + 1'b1;

      // tick lands on phase 0 of the next frame
      frame_tick <= last_phase;

      if (last_phase) begin
        frame_cnt <= (frame_cnt == check_bits'(check_period - 1)) ? '0 : frame_cnt + 1'b1;
      end

      // strobe is always coincident with a frame tick
      check_strobe <= last_phase && (frame_cnt == check_bits'(check_period - 1));
    end
  end

endmodule

// ==== source/sof_lock_monitor.sv ====
`timescale 1ns/100ps

module sof_lock_monitor (
  input  logic                          fastclock,
  input  logic                          rst,
  input  logic                          frame_tick,
  input  logic                          check_strobe,
  input  logic                          sof_dly,
  output logic [frame_pkg::tap_bits-1:0] tap,
  output logic                          locked,
  output logic                          alignment_error,
  output logic                          aligned
);

  import frame_pkg::*;

  // ---------------------------------------------------------------------
  // clean rising edge of the delayed sof
  // ---------------------------------------------------------------------

  // two cycles of history, an inverted or stuck sof is high here
  // and so never passes as a fresh edge
  logic sof_last;
  logic sof_last_last;

  always_ff @(posedge fastclock) begin
    if (rst) begin
      // start high so the first cycles after reset cannot look like an edge
      sof_last      <= 1'b1;
      sof_last_last <= 1'b1;
    end else begin
      sof_last      <= sof_dly;
      sof_last_last <= sof_last;
    end
  end

  // edge must fall exactly on the frame phase of the shared timer
  assign aligned = frame_tick && sof_dly && !sof_last && !sof_last_last;

  // ---------------------------------------------------------------------
  // tap search and lock
  // ---------------------------------------------------------------------

  // aligned frames seen in a row, parks at mxstable-1 once locked
  logic [stable_bits-1:0] stable_cnt;

  always_ff @(posedge fastclock) begin
    if (rst) begin
      tap             <= '0;
      stable_cnt      <= '0;
      locked          <= 1'b0;
      alignment_error <= 1'b0;
    end else begin
      // step only on the strobe so the previous tap had time to show up
      // 4-bit tap wraps back to zero after the last tap
      if (check_strobe && !aligned) begin
        tap <= tap + 1'b1;
      end

      if (frame_tick) begin
        if (aligned) begin
          if (!locked) begin
            if (stable_cnt == stable_bits'(mxstable - 1)) begin
              locked          <= 1'b1;
              alignment_error <= 1'b0;
            end else begin
              stable_cnt <= stable_cnt + 1'b1;
            end
          end
        end else begin
          // a single missed frame drops lock and restarts the count
          stable_cnt <= '0;
          locked     <= 1'b0;

          // error only means something once we had lock
          if (locked) begin
            alignment_error <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== source/frame_aligner.sv ====
`timescale 1ns/100ps

module frame_aligner (
  input  logic                         fastclock,
  input  logic                         rst,
  input  logic                         frame_tick,
  input  logic                         check_strobe,
  input  logic [frame_pkg::mxio-1:0]    d0,
  input  logic [frame_pkg::mxio-1:0]    d1,
  input  logic                         start_of_frame,
  input  logic                         mask,
  output logic [frame_pkg::mxsbits-1:0] sbits,
  output logic                         sbits_valid,
  output logic                         sof_delayed,
  output logic                         locked,
  output logic                         alignment_error
);

  import frame_pkg::*;

  // pairs per frame on each pin
  localparam int half_word = word_size / 2;

  // ---------------------------------------------------------------------
  // input registers
  // ---------------------------------------------------------------------

  // d0 carries the even bit of each pair, d1 the odd bit
  logic [mxio-1:0] d0_ff;
  logic [mxio-1:0] d1_ff;
  logic            sof_ff;

  always_ff @(posedge fastclock) begin
    d0_ff <= d0;
    d1_ff <= d1;
  end

  always_ff @(posedge fastclock) begin
    if (rst) begin
      sof_ff <= 1'b0;
    end else begin
      sof_ff <= start_of_frame;
    end
  end

  // ---------------------------------------------------------------------
  // variable delay, one tap shared by sof and data
  // ---------------------------------------------------------------------

  logic [tap_bits-1:0] tap;
  logic [mxio-1:0]     d0_dly;
  logic [mxio-1:0]     d1_dly;
  logic                sof_line;

  bit_delay_line #(.width(mxio)) u_d0_delay (
    .fastclock (fastclock),
    .din       (d0_ff),
    .tap       (tap),
    .dout      (d0_dly)
  );

  bit_delay_line #(.width(mxio)) u_d1_delay (
    .fastclock (fastclock),
    .din       (d1_ff),
    .tap       (tap),
    .dout      (d1_dly)
  );

  bit_delay_line #(.width(1)) u_sof_delay (
    .fastclock (fastclock),
    .din       (sof_ff),
    .tap       (tap),
    .dout      (sof_line)
  );

  // fixed extra sof stages, lines the pulse up with word_s1 below
  logic [sof_extra_delay-1:0] sof_pipe;
  logic                       sof_dly;

  always_ff @(posedge fastclock) begin
    if (rst) begin
      sof_pipe <= '0;
    end else begin
      sof_pipe[0] <= sof_line;
      for (int i = 1; i < sof_extra_delay; i++) begin
        sof_pipe[i] <= sof_pipe[i-1];
      end
    end
  end

  assign sof_dly     = sof_pipe[sof_extra_delay-1];
  assign sof_delayed = sof_dly;

  // ---------------------------------------------------------------------
  // alignment search and lock
  // ---------------------------------------------------------------------

  logic aligned;

  sof_lock_monitor u_sof_lock_monitor (
    .fastclock       (fastclock),
    .rst             (rst),
    .frame_tick      (frame_tick),
    .check_strobe    (check_strobe),
    .sof_dly         (sof_dly),
    .tap             (tap),
    .locked          (locked),
    .alignment_error (alignment_error),
    .aligned         (aligned)
  );

  // ---------------------------------------------------------------------
  // deserializer
  // ---------------------------------------------------------------------

  // first pair is oldest, so it ends up in the top bit of each row
  logic [half_word-1:0] even_sr [mxio];
  logic [half_word-1:0] odd_sr  [mxio];

  // word_s0 holds a complete frame one cycle after its last pair lands,
  // word_s1 then lines it up with the tick of the following frame
  logic [mxsbits-1:0] word_s0;
  logic [mxsbits-1:0] word_s1;

  // even bit goes above its odd partner, first pair on bits 7 and 6
  function automatic logic [word_size-1:0] interleave(
    input logic [half_word-1:0] even,
    input logic [half_word-1:0] odd
  );
    logic [word_size-1:0] byte_out;
    for (int i = 0; i < half_word; i++) begin
      byte_out[2*i+1] = even[i];
      byte_out[2*i]   = odd[i];
    end
    return byte_out;
  endfunction

  always_ff @(posedge fastclock) begin
    for (int p = 0; p < mxio; p++) begin
      even_sr[p] <= {even_sr[p][half_word-2:0], d0_dly[p]};
      odd_sr[p]  <= {odd_sr[p][half_word-2:0], d1_dly[p]};

      // pin p owns byte p of the word
      word_s0[p*word_size +: word_size] <= interleave(even_sr[p], odd_sr[p]);
    end
    word_s1 <= word_s0;
  end

  // ---------------------------------------------------------------------
  // output word
  // ---------------------------------------------------------------------

  // one word per aligned frame, zeros while masked or hunting for lock
  always_ff @(posedge fastclock) begin
    if (rst || mask || !locked) begin
      sbits       <= '0;
      sbits_valid <= 1'b0;
    end else if (aligned) begin
      sbits       <= word_s1;
      sbits_valid <= 1'b1;
    end else begin
      sbits_valid <= 1'b0;
    end
  end

endmodule

// ==== source/sbit_receiver.sv ====
`timescale 1ns/100ps

module sbit_receiver (
  input  logic                                                  fastclock,
  input  logic                                                  rst,
  input  logic [frame_pkg::num_channels-1:0][frame_pkg::mxio-1:0]    d0,
  input  logic [frame_pkg::num_channels-1:0][frame_pkg::mxio-1:0]    d1,
  input  logic [frame_pkg::num_channels-1:0]                    start_of_frame,
  input  logic [frame_pkg::num_channels-1:0]                    mask,
  output logic [frame_pkg::num_channels-1:0][frame_pkg::mxsbits-1:0] sbits,
  output logic [frame_pkg::num_channels-1:0]                    sbits_valid,
  output logic [frame_pkg::num_channels-1:0]                    sof_delayed,
  output logic [frame_pkg::num_channels-1:0]                    locked,
  output logic [frame_pkg::num_channels-1:0]                    alignment_error
);

  import frame_pkg::*;

  // ---------------------------------------------------------------------
  // shared frame timing
  // ---------------------------------------------------------------------

  // one timer so every channel aligns to the same frame boundary
  logic frame_tick;
  logic check_strobe;

  frame_timer u_frame_timer (
    .fastclock    (fastclock),
    .rst          (rst),
    .frame_tick   (frame_tick),
    .check_strobe (check_strobe)
  );

  // ---------------------------------------------------------------------
  // channels
  // ---------------------------------------------------------------------

  // each channel runs its own tap search against the shared tick
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    frame_aligner u_frame_aligner (
      .fastclock       (fastclock),
      .rst             (rst),
      .frame_tick      (frame_tick),
      .check_strobe    (check_strobe),
      .d0              (d0[ch]),
      .d1              (d1[ch]),
      .start_of_frame  (start_of_frame[ch]),
      .mask            (mask[ch]),
      .sbits           (sbits[ch]),
      .sbits_valid     (sbits_valid[ch]),
      .sof_delayed     (sof_delayed[ch]),
      .locked          (locked[ch]),
      .alignment_error (alignment_error[ch])
    );
  end

endmodule

// ==== test/vfat_stream_model.sv ====
`timescale 1ns/100ps

module vfat_stream_model #(
  parameter int seed_init = 86
) (
  input  logic                           fastclock,
  input  logic                           restart,
  input  logic [frame_pkg::tap_bits-1:0] lag,
  input  logic                           invert_sof,
  input  logic                           drop_sof,
  output logic [frame_pkg::mxio-1:0]     d0,
  output logic [frame_pkg::mxio-1:0]     d1,
  output logic                           start_of_frame,
  output logic [frame_pkg::mxsbits-1:0]  sent_word,
  output logic                           sent_strobe
);

  import frame_pkg::*;

  int seed;
  int idle_left;
  int pair;
  logic [mxsbits-1:0] word;
  logic sof_raw;

  // controls are taken on the rising edge, the serial drive happens on the falling edge
  logic restart_q = 1'b0;
  logic [tap_bits-1:0] lag_q = '0;
  logic invert_q = 1'b0;
  logic drop_q = 1'b0;

  initial begin
    seed           = seed_init;
    idle_left      = 0;
    pair           = 0;
    word           = '0;
    d0             = '0;
    d1             = '0;
    start_of_frame = 1'b0;
    sent_word      = '0;
    sent_strobe    = 1'b0;
  end

  always @(posedge fastclock) begin
    restart_q <= restart;
    lag_q     <= lag;
    invert_q  <= invert_sof;
    drop_q    <= drop_sof;
  end

  // ---------------------------------------------------------------------
  // serial frames, first pair carries bits 7 and 6 of every pin byte
  // ---------------------------------------------------------------------

  always @(negedge fastclock) begin
    sent_strobe <= 1'b0;
    sof_raw = 1'b0;
    if (restart_q) begin
      // lag is the count of idle cycles before the first frame
      idle_left = int'(lag_q);
      pair      = 0;
      d0 <= '0;
      d1 <= '0;
    end else if (idle_left > 0) begin
      idle_left--;
      d0 <= '0;
      d1 <= '0;
    end else begin
      if (pair == 0) begin
        word = {$random(seed), $random(seed)};
        // publish the word so the testbench can keep the sent sequence
        sent_word   <= word;
        sent_strobe <= 1'b1;
        sof_raw = 1'b1;
      end
      for (int p = 0; p < mxio; p++) begin
        d0[p] <= word[p*word_size + word_size - 1 - 2*pair];
        d1[p] <= word[p*word_size + word_size - 2 - 2*pair];
      end
      pair = (pair == frame_cycles - 1) ? 0 : pair + 1;
    end
    // fault modes act on the sof pin only
    start_of_frame <= !drop_q && (sof_raw ^ invert_q);
  end

endmodule

// ==== test/sbit_receiver_tb.sv ====
`timescale 1ns/100ps

module sbit_receiver_tb;

  import frame_pkg::*;

  localparam int seed = 86;
  localparam int num_tests = 7;
  localparam int lock_margin = 64;
  // full tap sweep plus the stable run, in cycles
  localparam int lock_budget = (srl_depth * check_period + mxstable) * frame_cycles + lock_margin;

  // sof fault on channel 0
  localparam logic [1:0] fault_none   = 2'd0;
  localparam logic [1:0] fault_invert = 2'd1;
  localparam logic [1:0] fault_drop   = 2'd2;

  typedef struct packed {
    logic [tap_bits-1:0]     lag0;
    logic [tap_bits-1:0]     lag1;
    logic [num_channels-1:0] mask;
    logic [1:0]              fault;
    logic                    mid_reset;
    logic [15:0]             frames;
    logic [num_channels-1:0] exp_lock;
  } test_row_t;

  // lag0, lag1, mask, fault, mid reset, steady frames, expected lock
  test_row_t tests [num_tests] = '{
    '{4'd0,  4'd0,  2'b00, fault_none,   1'b0, 16'd40, 2'b11},
    '{4'd3,  4'd7,  2'b00, fault_none,   1'b0, 16'd40, 2'b11},
    '{4'd13, 4'd3,  2'b00, fault_none,   1'b0, 16'd40, 2'b11},
    '{4'd7,  4'd13, 2'b01, fault_none,   1'b0, 16'd40, 2'b11},
    '{4'd5,  4'd2,  2'b00, fault_invert, 1'b0, 16'd40, 2'b10},
    '{4'd2,  4'd9,  2'b00, fault_drop,   1'b0, 16'd40, 2'b11},
    '{4'd11, 4'd6,  2'b00, fault_none,   1'b1, 16'd40, 2'b11}
  };

  logic fastclock = 1'b0;
  logic rst = 1'b1;
  logic [num_channels-1:0] mask = '0;
  logic [num_channels-1:0] restart = '0;
  logic [num_channels-1:0] invert_sof = '0;
  logic [num_channels-1:0] drop_sof = '0;
  logic [num_channels-1:0][tap_bits-1:0] lag = '0;
  wire  [num_channels-1:0][mxio-1:0] d0;
  wire  [num_channels-1:0][mxio-1:0] d1;
  wire  [num_channels-1:0] start_of_frame;
  wire  [num_channels-1:0] sent_strobe;
  wire  [num_channels-1:0][mxsbits-1:0] sent_word;
  logic [num_channels-1:0][mxsbits-1:0] sbits;
  logic [num_channels-1:0] sbits_valid;
  logic [num_channels-1:0] sof_delayed;
  logic [num_channels-1:0] locked;
  logic [num_channels-1:0] alignment_error;

  // sent words per channel, and the checker's place in them
  logic [mxsbits-1:0] sent_q [num_channels][$];
  logic [num_channels-1:0] synced = '0;
  // delayed sof as seen one cycle earlier
  logic [num_channels-1:0] sof_prev = '0;
  int next_idx [num_channels];
  int word_count [num_channels];
  logic check_en = 1'b0;
  logic count_en = 1'b0;
  int error_count = 0;
  int passed = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  always #5 fastclock = ~fastclock;

  sbit_receiver u_sbit_receiver (
    .fastclock       (fastclock),
    .rst             (rst),
    .d0              (d0),
    .d1              (d1),
    .start_of_frame  (start_of_frame),
    .mask            (mask),
    .sbits           (sbits),
    .sbits_valid     (sbits_valid),
    .sof_delayed     (sof_delayed),
    .locked          (locked),
    .alignment_error (alignment_error)
  );

  for (genvar ch = 0; ch < num_channels; ch++) begin : g_model
    vfat_stream_model #(.seed_init(seed + ch)) u_vfat_stream_model (
      .fastclock      (fastclock),
      .restart        (restart[ch]),
      .lag            (lag[ch]),
      .invert_sof     (invert_sof[ch]),
      .drop_sof       (drop_sof[ch]),
      .d0             (d0[ch]),
      .d1             (d1[ch]),
      .start_of_frame (start_of_frame[ch]),
      .sent_word      (sent_word[ch]),
      .sent_strobe    (sent_strobe[ch])
    );
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------

  task automatic check_value(input string name, input logic [mxsbits-1:0] expected,
                             input logic [mxsbits-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  function automatic int find_word(input int ch, input logic [mxsbits-1:0] word);
    for (int i = 0; i < sent_q[ch].size(); i++) begin
      if (sent_q[ch][i] === word) begin
        return i;
      end
    end
    return -1;
  endfunction

  // steady frames and fault frames of every row, plus a lock budget per lock wait
  function automatic int run_cycle_limit();
    int total;
    total = 0;
    for (int i = 0; i < num_tests; i++) begin
      total += frame_cycles * (int'(tests[i].frames) + 16) + lock_budget + 16;
      if (tests[i].fault == fault_drop || tests[i].mid_reset) begin
        total += lock_budget;
      end
    end
    return total;
  endfunction

  task automatic run_frames(input int n);
    repeat (n * frame_cycles) @(negedge fastclock);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(negedge fastclock);
    rst = 1'b0;
  endtask

  task automatic wait_lock(input logic [num_channels-1:0] want);
    int waited;
    waited = 0;
    while ((locked & want) != want && waited < lock_budget) begin
      @(negedge fastclock);
      waited++;
    end
    if ((locked & want) != want) begin
      $display("channels %b did not lock within %0d cycles, locked is %b",
               want, lock_budget, locked);
      error_count++;
    end
  endtask

  // ---------------------------------------------------------------------
  // sent word record and output checker
  // ---------------------------------------------------------------------

  always @(posedge fastclock) begin
    for (int ch = 0; ch < num_channels; ch++) begin
      if (sent_strobe[ch]) begin
        sent_q[ch].push_back(sent_word[ch]);
      end
    end
  end

  always @(negedge fastclock) begin
    for (int ch = 0; ch < num_channels; ch++) begin
      if (!check_en || !locked[ch]) begin
        synced[ch] = 1'b0;
      end
      // every pulse counts, so a stray word on a silent channel shows up too
      if (check_en && count_en && sbits_valid[ch]) begin
        word_count[ch]++;
      end
      if (check_en && (mask[ch] || invert_sof[ch])) begin
        // masked or never aligned, the channel stays silent
        check_value($sformatf("sbits_valid[%0d]", ch), '0, sbits_valid[ch]);
        check_value($sformatf("sbits[%0d]", ch), '0, sbits[ch]);
        if (invert_sof[ch]) begin
          check_value($sformatf("locked[%0d]", ch), '0, locked[ch]);
        end
      end else if (check_en && sbits_valid[ch]) begin
        // a word follows the frame tick that saw the delayed sof high
        check_value($sformatf("sof_delayed[%0d]", ch), 1, sof_prev[ch]);
        if (!synced[ch]) begin
          // first word after a lock picks the place in the sent sequence
          next_idx[ch] = find_word(ch, sbits[ch]) + 1;
          synced[ch]   = 1'b1;
          if (next_idx[ch] == 0) begin
            $display("channel %0d delivered a word at %0t that was never sent", ch, $time);
            error_count++;
          end
        end else if (next_idx[ch] >= sent_q[ch].size()) begin
          $display("channel %0d delivered more words than were sent", ch);
          error_count++;
        end else begin
          check_value($sformatf("sbits[%0d]", ch), sent_q[ch][next_idx[ch]], sbits[ch]);
          next_idx[ch]++;
        end
      end
      sof_prev[ch] = sof_delayed[ch];
    end
  end

  // hang guard
  always @(posedge fastclock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: test table not done within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // one table row
  // ---------------------------------------------------------------------

  task automatic run_test(input int idx);
    test_row_t row;
    int errors_before;
    int expect_words;
    string verdict;
    row = tests[idx];
    errors_before = error_count;
    @(posedge fastclock);
    check_en = 1'b0;
    @(negedge fastclock);
    mask       = row.mask;
    lag        = {row.lag1, row.lag0};
    invert_sof = {1'b0, row.fault == fault_invert};
    drop_sof   = '0;
    restart    = '1;
    for (int ch = 0; ch < num_channels; ch++) begin
      sent_q[ch].delete();
    end
    @(negedge fastclock);
    restart = '0;
    apply_reset();
    @(posedge fastclock);
    check_en = 1'b1;
    @(negedge fastclock);
    wait_lock(row.exp_lock);

    if (row.fault == fault_drop) begin
      run_frames(8);
      drop_sof[0] = 1'b1;
      // long enough for the longest tap to flush
      run_frames(8);
      check_value("locked[0]", '0, locked[0]);
      check_value("alignment_error[0]", 1, alignment_error[0]);
      check_value("locked[1]", 1, locked[1]);
      drop_sof[0] = 1'b0;
      wait_lock(row.exp_lock);
      check_value("alignment_error[0]", '0, alignment_error[0]);
    end

    if (row.mid_reset) begin
      run_frames(8);
      apply_reset();
      check_value("locked", '0, locked);
      check_value("alignment_error", '0, alignment_error);
      for (int ch = 0; ch < num_channels; ch++) begin
        check_value($sformatf("sbits[%0d]", ch), '0, sbits[ch]);
      end
      wait_lock(row.exp_lock);
    end

    // steady window, one word per frame on every open locked channel
    for (int ch = 0; ch < num_channels; ch++) begin
      word_count[ch] = 0;
    end
    @(posedge fastclock);
    count_en = 1'b1;
    repeat (row.frames * frame_cycles) @(posedge fastclock);
    count_en = 1'b0;
    @(negedge fastclock);
    check_value("locked", row.exp_lock, locked);
    for (int ch = 0; ch < num_channels; ch++) begin
      expect_words = (row.exp_lock[ch] && !row.mask[ch]) ? int'(row.frames) : 0;
      check_value($sformatf("word count %0d", ch), expect_words, word_count[ch]);
    end

    if (error_count == errors_before) begin
      passed++;
      verdict = "ok";
    end else begin
      verdict = $sformatf("%0d errors", error_count - errors_before);
    end
    $display("test %0d lag %0d/%0d mask %b fault %0d mid reset %0d: %s",
             idx, row.lag0, row.lag1, row.mask, row.fault, row.mid_reset, verdict);
  endtask

  initial begin
    cycle_limit = run_cycle_limit();
    repeat (2) @(negedge fastclock);
    rst = 1'b0;
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_tests, passed, num_tests - passed, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
source/frame_pkg.sv
source/bit_delay_line.sv
source/frame_timer.sv
source/sof_lock_monitor.sv
source/frame_aligner.sv
source/sbit_receiver.sv
test/vfat_stream_model.sv
test/sbit_receiver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module sbit_receiver_tb -f src.f -o sbit_sim \
  && ./obj_dir/sbit_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
